// File: common/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // data path and address widths
    typedef logic [63:0] data_t;
    typedef logic [63:0] addr_t;

    // one enable bit per byte lane of a data word
    typedef logic [7:0] strb_t;

    typedef enum logic [1:0] {
        REQ_NONE  = 2'd0,
        REQ_READ  = 2'd1,
        REQ_WRITE = 2'd2
    } req_kind_t;

    // access size, log2 of the byte count
    typedef logic [1:0] size_t;

    localparam size_t SIZE_B = 2'd0;
    localparam size_t SIZE_H = 2'd1;
    localparam size_t SIZE_W = 2'd2;
    localparam size_t SIZE_D = 2'd3;

    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_DECERR = 2'd3;

    // clint region, 64 KiB window
    localparam addr_t CLINT_BASE = 64'h0000_0000_0200_0000;
    localparam addr_t CLINT_MASK = 64'hffff_ffff_ffff_0000;

    // register offsets inside the clint window
    localparam addr_t MTIMECMP_OFS = 64'h0000_0000_0000_4000;
    localparam addr_t MTIME_OFS    = 64'h0000_0000_0000_bff8;

    // data ram, 256 doublewords
    localparam int    RAM_DEPTH_LOG2 = 8;
    localparam addr_t RAM_BASE       = 64'h0000_0000_8000_0000;
    localparam addr_t RAM_MASK       = ~((addr_t'(1) << (RAM_DEPTH_LOG2 + 3)) - addr_t'(1));

    // mtime steps once every 2**MTIME_PRESCALE_LOG2 clocks
    localparam int MTIME_PRESCALE_LOG2 = 4;

endpackage

`default_nettype wire

// File: common/mem_req_if.sv
`timescale 1ns/1ps
`default_nettype none

// one target port of the router
// a transfer happens when valid and ready are both high, rdata follows one cycle later
interface mem_req_if;

    logic               valid;
    mem_pkg::req_kind_t kind;
    mem_pkg::addr_t     addr;
    mem_pkg::size_t     size;
    mem_pkg::data_t     wdata;
    logic               ready;
    mem_pkg::data_t     rdata;

    modport router (
        output valid,
        output kind,
        output addr,
        output size,
        output wdata,
        input  ready,
        input  rdata
    );

    modport target (
        input  valid,
        input  kind,
        input  addr,
        input  size,
        input  wdata,
        output ready,
        output rdata
    );

endinterface

`default_nettype wire

// File: src/mem_clint.sv
`timescale 1ns/1ps
`default_nettype none

module mem_clint (
    input  wire          clk,
    input  wire          rst,
    mem_req_if.target    bus_i,
    output logic         mtip_o,
    output logic         update_o
);

    logic [mem_pkg::MTIME_PRESCALE_LOG2-1:0] presc_q;
    logic                                    tick;
    mem_pkg::data_t                          mtime_q;
    mem_pkg::data_t                          mtimecmp_q;
    mem_pkg::data_t                          rdata_q;
    mem_pkg::addr_t                          ofs;
    logic                                    access;
    logic                                    rd_en;
    logic                                    wr_en;
    logic                                    mtime_sel;
    logic                                    mtimecmp_sel;
    logic                                    update_q;

    // never stalls
    assign bus_i.ready = 1'b1;

    assign access = bus_i.valid && bus_i.ready;
    assign rd_en  = access && (bus_i.kind == mem_pkg::REQ_READ);
    assign wr_en  = access && (bus_i.kind == mem_pkg::REQ_WRITE);

    // offset inside the window, every access treated as a doubleword
    assign ofs = bus_i.addr & ~mem_pkg::CLINT_MASK & ~mem_pkg::addr_t'(7);

    assign mtime_sel    = (ofs == mem_pkg::MTIME_OFS);
    assign mtimecmp_sel = (ofs == mem_pkg::MTIMECMP_OFS);

    // free running prescaler, mtime steps when it wraps to zero
    always_ff @(posedge clk) begin
        if (rst) begin
            presc_q <= '0;
        end else begin
            presc_q <= presc_q + 1'b1;
        end
    end

    assign tick = (presc_q == '0);

    // software write wins over the tick
    always_ff @(posedge clk) begin
        if (rst) begin
            mtime_q <= '0;
        end else if (wr_en && mtime_sel) begin
            mtime_q <= bus_i.wdata;
        end else if (tick) begin
            mtime_q <= mtime_q + 64'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mtimecmp_q <= '0;
        end else if (wr_en && mtimecmp_sel) begin
            mtimecmp_q <= bus_i.wdata;
        end
    end

    // registered read so timing matches the ram
    always_ff @(posedge clk) begin
        if (rst) begin
            rdata_q <= '0;
        end else if (rd_en) begin
            if (mtime_sel) begin
                rdata_q <= mtime_q;
            end else if (mtimecmp_sel) begin
                rdata_q <= mtimecmp_q;
            end else begin
                rdata_q <= '0;
            end
        end
    end

    assign bus_i.rdata = rdata_q;

    // one cycle pulse after a write
    // a write right behind another gets no second pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            update_q <= 1'b0;
        end else begin
            update_q <= wr_en && !update_q;
        end
    end

    assign update_o = update_q;

    assign mtip_o = (mtime_q >= mtimecmp_q);

endmodule

`default_nettype wire

// File: src/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram (
    input  wire          clk,
    input  wire          rst,
    mem_req_if.target    bus_i
);

    localparam int DEPTH = 1 << mem_pkg::RAM_DEPTH_LOG2;

    mem_pkg::data_t                     mem_q [DEPTH];
    mem_pkg::data_t                     rdata_q;
    mem_pkg::strb_t                     lane_en;
    logic [mem_pkg::RAM_DEPTH_LOG2-1:0] row;
    logic                               access;
    logic                               rd_en;
    logic                               wr_en;

    // never stalls
    assign bus_i.ready = 1'b1;

    assign access = bus_i.valid && bus_i.ready;
    assign rd_en  = access && (bus_i.kind == mem_pkg::REQ_READ);
    assign wr_en  = access && (bus_i.kind == mem_pkg::REQ_WRITE);

    // doubleword index inside the ram
    assign row = bus_i.addr[mem_pkg::RAM_DEPTH_LOG2+2:3];

    // byte lanes touched by the access, aligned down to the size
    always_comb begin
        case (bus_i.size)
            mem_pkg::SIZE_B: lane_en = 8'b0000_0001 << bus_i.addr[2:0];
            mem_pkg::SIZE_H: lane_en = 8'b0000_0011 << {bus_i.addr[2:1], 1'b0};
            mem_pkg::SIZE_W: lane_en = 8'b0000_1111 << {bus_i.addr[2], 2'b00};
            default:         lane_en = 8'b1111_1111;
        endcase
    end

    // write data already sits in the lanes its address selects
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < 8; i++) begin
                if (lane_en[i]) begin
                    mem_q[row][8*i +: 8] <= bus_i.wdata[8*i +: 8];
                end
            end
        end
    end

    // synchronous read of the whole doubleword
    always_ff @(posedge clk) begin
        if (rst) begin
            rdata_q <= '0;
        end else if (rd_en) begin
            rdata_q <= mem_q[row];
        end
    end

    assign bus_i.rdata = rdata_q;

endmodule

`default_nettype wire

// File: src/mem_access_router.sv
`timescale 1ns/1ps
`default_nettype none

module mem_access_router (
    input  wire                       clk,
    input  wire                       rst,

    input  wire                       req_valid_i,
    input  wire mem_pkg::req_kind_t   req_kind_i,
    input  wire mem_pkg::addr_t       req_addr_i,
    input  wire mem_pkg::size_t       req_size_i,
    input  wire mem_pkg::data_t       req_wdata_i,
    output logic                      req_ready_o,

    output logic                      rsp_valid_o,
    output mem_pkg::data_t            rsp_rdata_o,
    output mem_pkg::resp_t            rsp_resp_o,

    mem_req_if.router                 clint_o,
    mem_req_if.router                 ram_o
);

    logic hit_clint;
    logic hit_ram;
    logic accept;

    // response record, one per accepted request
    logic rsp_valid_q;
    logic rsp_sel_ram_q;
    logic rsp_read_q;
    logic rsp_err_q;

    // region decode
    assign hit_clint = ((req_addr_i & mem_pkg::CLINT_MASK) == mem_pkg::CLINT_BASE);
    assign hit_ram   = ((req_addr_i & mem_pkg::RAM_MASK) == mem_pkg::RAM_BASE);

    // both targets always ready, so the port never stalls
    assign req_ready_o = clint_o.ready && ram_o.ready;
    assign accept      = req_valid_i && req_ready_o;

    // valid only toward the matching target
    assign clint_o.valid = req_valid_i && hit_clint;
    assign clint_o.kind  = req_kind_i;
    assign clint_o.addr  = req_addr_i;
    assign clint_o.size  = req_size_i;
    assign clint_o.wdata = req_wdata_i;

    assign ram_o.valid = req_valid_i && hit_ram;
    assign ram_o.kind  = req_kind_i;
    assign ram_o.addr  = req_addr_i;
    assign ram_o.size  = req_size_i;
    assign ram_o.wdata = req_wdata_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid_q   <= 1'b0;
            rsp_sel_ram_q <= 1'b0;
            rsp_read_q    <= 1'b0;
            rsp_err_q     <= 1'b0;
        end else begin
            rsp_valid_q   <= accept;
            rsp_sel_ram_q <= hit_ram;
            rsp_read_q    <= accept && (req_kind_i == mem_pkg::REQ_READ);
            rsp_err_q     <= accept && !hit_clint && !hit_ram;
        end
    end

    assign rsp_valid_o = rsp_valid_q;

    // read data of the remembered target, zero for writes and errors
    always_comb begin
        if (!rsp_read_q || rsp_err_q) begin
            rsp_rdata_o = '0;
        end else if (rsp_sel_ram_q) begin
            rsp_rdata_o = ram_o.rdata;
        end else begin
            rsp_rdata_o = clint_o.rdata;
        end
    end

    assign rsp_resp_o = rsp_err_q ? mem_pkg::RESP_DECERR : mem_pkg::RESP_OKAY;

endmodule

`default_nettype wire

// File: src/mem_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top (
    input  wire                       clk,
    input  wire                       rst,

    input  wire                       req_valid_i,
    input  wire mem_pkg::req_kind_t   req_kind_i,
    input  wire mem_pkg::addr_t       req_addr_i,
    input  wire mem_pkg::size_t       req_size_i,
    input  wire mem_pkg::data_t       req_wdata_i,
    output logic                      req_ready_o,

    output logic                      rsp_valid_o,
    output mem_pkg::data_t            rsp_rdata_o,
    output mem_pkg::resp_t            rsp_resp_o,

    // machine timer interrupt and clint write strobe
    output logic                      mtip_o,
    output logic                      clint_update_o
);

    mem_req_if clint_bus ();
    mem_req_if ram_bus ();

    mem_access_router u_router (
        .clk         (clk),
        .rst         (rst),
        .req_valid_i (req_valid_i),
        .req_kind_i  (req_kind_i),
        .req_addr_i  (req_addr_i),
        .req_size_i  (req_size_i),
        .req_wdata_i (req_wdata_i),
        .req_ready_o (req_ready_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_rdata_o (rsp_rdata_o),
        .rsp_resp_o  (rsp_resp_o),
        .clint_o     (clint_bus.router),
        .ram_o       (ram_bus.router)
    );

    mem_clint u_clint (
        .clk      (clk),
        .rst      (rst),
        .bus_i    (clint_bus.target),
        .mtip_o   (mtip_o),
        .update_o (clint_update_o)
    );

    data_ram u_ram (
        .clk   (clk),
        .rst   (rst),
        .bus_i (ram_bus.target)
    );

endmodule

`default_nettype wire

// File: tb/mem_subsys_assert.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_assert (
    input wire                 clk,
    input wire                 rst,
    input wire                 req_valid_i,
    input wire                 req_ready_i,
    input wire mem_pkg::addr_t req_addr_i,
    input wire                 rsp_valid_i,
    input wire mem_pkg::resp_t rsp_resp_i,
    input wire                 clint_update_i
);

    int   fail_count = 0;
    logic accepted;
    logic mapped;

    assign accepted = req_valid_i && req_ready_i;

    // clint window or the 2 KiB ram
    assign mapped = (req_addr_i[63:16] == 48'h0200) ||
                    ((req_addr_i >= 64'h8000_0000) && (req_addr_i < 64'h8000_0800));

    rsp_follows_req: assert property (@(posedge clk) disable iff (rst)
        accepted |=> rsp_valid_i)
        else begin
            $error("response missing one cycle after an accepted request");
            fail_count++;
        end

    no_extra_rsp: assert property (@(posedge clk) disable iff (rst)
        !accepted |=> !rsp_valid_i)
        else begin
            $error("response without an accepted request");
            fail_count++;
        end

    update_single: assert property (@(posedge clk) disable iff (rst)
        clint_update_i |=> !clint_update_i)
        else begin
            $error("clint update high on two cycles in a row");
            fail_count++;
        end

    mapped_okay: assert property (@(posedge clk) disable iff (rst)
        (accepted && mapped) |=> (rsp_resp_i == mem_pkg::RESP_OKAY))
        else begin
            $error("mapped address answered with an error response");
            fail_count++;
        end

endmodule

bind mem_subsys_top mem_subsys_assert u_assert (
    .clk            (clk),
    .rst            (rst),
    .req_valid_i    (req_valid_i),
    .req_ready_i    (req_ready_o),
    .req_addr_i     (req_addr_i),
    .rsp_valid_i    (rsp_valid_o),
    .rsp_resp_i     (rsp_resp_o),
    .clint_update_i (clint_update_o)
);

`default_nettype wire

// File: tb/mem_subsys_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_tb;

    logic               clk;
    logic               rst;
    logic               req_valid_i;
    mem_pkg::req_kind_t req_kind_i;
    mem_pkg::addr_t     req_addr_i;
    mem_pkg::size_t     req_size_i;
    mem_pkg::data_t     req_wdata_i;
    logic               req_ready_o;
    logic               rsp_valid_o;
    mem_pkg::data_t     rsp_rdata_o;
    mem_pkg::resp_t     rsp_resp_o;
    logic               mtip_o;
    logic               clint_update_o;

    // reference model state
    logic [7:0]  ram_model [2048];
    logic [63:0] mtime_m;
    logic [63:0] mtimecmp_m;
    int          edge_cnt;
    logic        upd_exp;
    logic        cur_chk;
    logic [63:0] cur_exp;
    int          error_count;
    int          check_count;
    int          num_cases;
    logic        cases_known;
    integer      seed;

    mem_subsys_top UUT (
        .clk            (clk),
        .rst            (rst),
        .req_valid_i    (req_valid_i),
        .req_kind_i     (req_kind_i),
        .req_addr_i     (req_addr_i),
        .req_size_i     (req_size_i),
        .req_wdata_i    (req_wdata_i),
        .req_ready_o    (req_ready_o),
        .rsp_valid_o    (rsp_valid_o),
        .rsp_rdata_o    (rsp_rdata_o),
        .rsp_resp_o     (rsp_resp_o),
        .mtip_o         (mtip_o),
        .clint_update_o (clint_update_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s, got %h, expected %h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic set_inputs(input logic valid, input mem_pkg::req_kind_t kind,
                              input logic [63:0] addr, input logic [1:0] size,
                              input logic [63:0] wdata, input logic chk, input logic [63:0] expv);
        req_valid_i = valid;
        req_kind_i  = kind;
        req_addr_i  = addr;
        req_size_i  = size;
        req_wdata_i = wdata;
        cur_chk     = chk;
        cur_exp     = expv;
    endtask

    // one clock edge: apply the request to the model, then check the outputs 1 ns later
    task automatic run_cycle();
        logic [63:0] a;
        logic [63:0] rd;
        logic [1:0]  resp;
        logic        acc;
        logic        wr_clint;
        int          nbytes;
        int          base;
        @(posedge clk);
        a        = req_addr_i;
        acc      = req_valid_i;
        rd       = '0;
        resp     = 2'd0;
        wr_clint = 1'b0;
        if (acc && (a >= 64'h8000_0000) && (a < 64'h8000_0800)) begin
            base = int'(a[10:0]);
            if (req_kind_i == mem_pkg::REQ_READ) begin
                for (int i = 0; i < 8; i++) begin
                    rd[8*i +: 8] = ram_model[(base & ~7) + i];
                end
            end else begin
                // aligned down to the size, data taken from the addressed lanes
                nbytes = 1 << req_size_i;
                base   = base & ~(nbytes - 1);
                for (int i = 0; i < nbytes; i++) begin
                    ram_model[base + i] = req_wdata_i[8*((base + i) % 8) +: 8];
                end
            end
        end else if (acc && (a[63:16] == 48'h0200)) begin
            if (req_kind_i == mem_pkg::REQ_READ) begin
                if ({a[15:3], 3'b000} == 16'hbff8) begin
                    rd = mtime_m;
                end else if ({a[15:3], 3'b000} == 16'h4000) begin
                    rd = mtimecmp_m;
                end
            end else begin
                wr_clint = 1'b1;
            end
        end else if (acc) begin
            resp = 2'd3;
        end
        if (wr_clint && ({a[15:3], 3'b000} == 16'hbff8)) begin
            mtime_m = req_wdata_i;
        end else if (edge_cnt % 16 == 0) begin
            mtime_m = mtime_m + 64'd1;
        end
        if (wr_clint && ({a[15:3], 3'b000} == 16'h4000)) begin
            mtimecmp_m = req_wdata_i;
        end
        edge_cnt++;
        // a clint write right behind a pulse does not pulse again
        upd_exp = wr_clint && !upd_exp;
        #1;
        check_value(req_ready_o, 1'b1, "request ready");
        check_value(rsp_valid_o, acc, "response valid");
        if (acc) begin
            check_value(rsp_rdata_o, rd, "read data against model");
            check_value(rsp_resp_o, resp, "response code");
            if (cur_chk) begin
                check_value(rsp_rdata_o, cur_exp, "read data against case file");
            end
        end
        check_value(clint_update_o, upd_exp, "clint update pulse");
        check_value(mtip_o, mtime_m >= mtimecmp_m, "timer interrupt");
    endtask

    initial begin
        integer           fd;
        integer           size_v;
        integer           gap;
        logic [8*160-1:0] line;
        logic [63:0]      op;
        logic [63:0]      addr;
        logic [63:0]      wdata;
        logic [63:0]      expv;
        rst         = 1'b1;
        seed        = 32'ha17;
        error_count = 0;
        check_count = 0;
        num_cases   = 0;
        cases_known = 1'b0;
        mtime_m     = '0;
        mtimecmp_m  = '0;
        edge_cnt    = 0;
        upd_exp     = 1'b0;
        set_inputs(1'b0, mem_pkg::REQ_NONE, '0, '0, '0, 1'b0, '0);
        fd = $fopen("tb/mem_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/mem_cases.txt");
            $display("*** TEST FAILED ***");
            $finish;
        end else begin
            // first pass counts the cases for the watchdog
            while ($fgets(line, fd)) begin
                if ($sscanf(line, "%s %h %d %h %h", op, addr, size_v, wdata, expv) == 5) begin
                    num_cases++;
                end
            end
            $fclose(fd);
            cases_known = 1'b1;
            repeat (4) @(posedge clk);
            #1;
            rst = 1'b0;
            check_value(rsp_valid_o, 1'b0, "response valid after reset");
            check_value(clint_update_o, 1'b0, "clint update after reset");
            check_value(mtip_o, 1'b1, "timer interrupt after reset");
            fd = $fopen("tb/mem_cases.txt", "r");
            while ($fgets(line, fd)) begin
                if ($sscanf(line, "%s %h %d %h %h", op, addr, size_v, wdata, expv) == 5) begin
                    case (op[7:0] | 8'h20)
                        "w": set_inputs(1'b1, mem_pkg::REQ_WRITE, addr, size_v[1:0], wdata,
                                        1'b0, '0);
                        "r": set_inputs(1'b1, mem_pkg::REQ_READ, addr, size_v[1:0], '0,
                                        1'b1, expv);
                        "t": set_inputs(1'b1, mem_pkg::REQ_READ, addr, size_v[1:0], '0,
                                        1'b0, '0);
                        default: set_inputs(1'b0, mem_pkg::REQ_NONE, '0, '0, '0, 1'b0, '0);
                    endcase
                    if ((op[7:0] | 8'h20) == "i") begin
                        repeat (wdata) run_cycle();
                        check_value(mtip_o, expv, "timer interrupt in case file");
                    end else begin
                        run_cycle();
                    end
                    set_inputs(1'b0, mem_pkg::REQ_NONE, '0, '0, '0, 1'b0, '0);
                    // lower case op: random idle gap, upper case: next case right away
                    if (op[7:0] >= "a") begin
                        gap = $unsigned($random(seed)) % 3;
                        repeat (gap) run_cycle();
                    end
                end
            end
            $fclose(fd);
            repeat (3) run_cycle();
            $display("checks: %0d, value errors: %0d, assertion errors: %0d",
                     check_count, error_count, UUT.u_assert.fail_count);
            if ((error_count == 0) && (UUT.u_assert.fail_count == 0)) begin
                $display("*** TEST PASSED ***");
            end else begin
                $display("*** TEST FAILED ***");
            end
            $finish;
        end
    end

    initial begin
        wait (cases_known);
        repeat (num_cases * 20 + 200) @(posedge clk);
        $display("timeout: cases did not finish within %0d cycles", num_cases * 20 + 200);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: mem_clint.f
common/mem_pkg.sv
common/mem_req_if.sv
src/mem_clint.sv
src/data_ram.sv
src/mem_access_router.sv
src/mem_subsys_top.sv
tb/mem_subsys_assert.sv
tb/mem_subsys_tb.sv

// File: tb/mem_cases.txt
# op addr size wdata expect, numbers in hex except size
# w write, r read against expect, t read against the model, i idle wdata cycles then mtip_o == expect
# an upper case op is followed by the next case on the very next cycle
W 80000000 3 0123456789abcdef 0
W 80000008 3 fedcba9876543210 0
R 80000000 3 0 0123456789abcdef
r 80000008 3 0 fedcba9876543210
W 80000000 0 00000000000000aa 0
W 80000003 0 0000000011000000 0
w 80000004 1 0000abcd00000000 0
w 80000007 1 5a5a000000000000 0
r 80000000 3 0 5a5aabcd11abcdaa
w 8000000c 2 0badf00d00000000 0
w 80000008 2 ffffffffc0ffee00 0
w 80000009 0 ffffffffffff99ff 0
r 80000008 3 0 0badf00dc0ff9900
w 02004000 3 0000000000001000 0
r 02004000 3 0 0000000000001000
w 0200bff8 3 0000000000000ffe 0
t 0200bff8 3 0 0
i 0 0 2 0
i 0 0 40 1
w 02004000 3 8000000000000000 0
i 0 0 1 0
w 0200bff8 3 9000000000000000 0
i 0 0 1 1
W 02004000 3 0000000000000777 0
w 02004004 2 0000000000000123 0
r 02004000 3 0 0000000000000123
w 02000010 3 ffffffffffffffff 0
r 02000010 3 0 0
w 10000000 3 deadbeefdeadbeef 0
r 10000000 3 0 0
W 80000800 3 deadbeefdeadbeef 0
R 80000800 3 0 0
w 0201bff8 3 0 0
r 180000000 3 0 0
r 80000000 3 0 5a5aabcd11abcdaa
r 80000008 3 0 0badf00dc0ff9900
r 02004000 3 0 0000000000000123
t 0200bff8 3 0 0
